//--- include/conv_engine_config.svh
`ifndef CONV_ENGINE_CONFIG_SVH
`define CONV_ENGINE_CONFIG_SVH

// Lanes per atom, one word each
`define CE_LANES 16

`define CE_WORD_W 16       // Data, weight and result word
`define CE_ADDR_W 30       // DMA word address

// Weight cache entries, also the largest legal atom count per point
`define CE_MAX_ATOMS 16

`define CE_RESULT_DEPTH 4  // Result queue entries

`endif

//--- rtl/conv_engine_pkg.sv
package conv_engine_pkg;

	`include "conv_engine_config.svh"

	typedef logic [`CE_WORD_W-1:0] word_t;     // One lane word
	typedef logic [`CE_ADDR_W-1:0] addr_t;     // DMA word address
	typedef word_t [`CE_LANES-1:0] atom_t;     // Lane 0 in the low word

	// Lane products are 2*W wide, the lane sum grows by log2(lanes)
	typedef logic [2*`CE_WORD_W+$clog2(`CE_LANES)-1:0] acc_t;

	typedef logic [$clog2(`CE_MAX_ATOMS):0] atom_cnt_t;  // Holds 0..CE_MAX_ATOMS
	typedef logic [7:0] point_cnt_t;

	// Read request, en is a one cycle strobe
	typedef struct packed {
		logic  en;
		addr_t addr;
	} dma_rd_req_t;

	// Write port outputs
	typedef struct packed {
		logic  writes_en;  // Level, a result is waiting
		addr_t addr;
		logic  ib_valid;   // Pulse, the cycle after ib_re
		word_t ib_data;
	} dma_wr_t;

	typedef enum logic [2:0] {
		idle,
		load_weights,
		stream,
		drain,
		finish
	} ctrl_state_t;

endpackage

//--- rtl/conv_engine_ctrl.sv
`timescale 1ns/10ps
`include "conv_engine_config.svh"

module conv_engine_ctrl (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         i_start,
	input  conv_engine_pkg::atom_cnt_t   i_atoms,
	input  conv_engine_pkg::point_cnt_t  i_points,
	input  conv_engine_pkg::addr_t       i_data_base,
	input  conv_engine_pkg::addr_t       i_weight_base,
	input  logic                         i_w_atom_valid,
	input  logic                         i_d_atom_valid,
	input  logic                         i_wb_full,
	input  logic                         i_wb_empty,
	output conv_engine_pkg::dma_rd_req_t o_w_req,
	output conv_engine_pkg::dma_rd_req_t o_d_req,
	output conv_engine_pkg::atom_cnt_t   o_tap,
	output logic                         o_last_atom,
	output logic                         o_done
);

	conv_engine_pkg::ctrl_state_t state;
	conv_engine_pkg::atom_cnt_t   atoms_q;   // Atoms per point
	conv_engine_pkg::point_cnt_t  points_q;
	conv_engine_pkg::point_cnt_t  point;     // Point being streamed
	conv_engine_pkg::atom_cnt_t   tap;       // Atom index inside the point
	conv_engine_pkg::addr_t       w_addr;
	conv_engine_pkg::addr_t       d_addr;
	logic                         w_busy;    // Weight request outstanding
	logic                         d_busy;    // Data request outstanding
	logic [2:0]                   last_pipe; // Last flag, follows the MAC and accumulator stages
	logic                         start_ok;
	logic                         last_tap;
	logic                         last_point;
	logic                         d_hold;

	assign start_ok   = i_start && (state == conv_engine_pkg::idle ||
		state == conv_engine_pkg::finish);
	assign last_tap   = (tap == atoms_q - conv_engine_pkg::atom_cnt_t'(1));
	assign last_point = (point == points_q - conv_engine_pkg::point_cnt_t'(1));

	// New point waits for queue room and for the previous point to land in the queue
	assign d_hold = (tap == '0) && (i_wb_full || (|last_pipe));

	assign o_tap       = tap;
	assign o_last_atom = last_pipe[1];  // Lines up with the MAC sum valid
	assign o_done      = (state == conv_engine_pkg::finish);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state     <= conv_engine_pkg::idle;
			atoms_q   <= '0;
			points_q  <= '0;
			point     <= '0;
			tap       <= '0;
			w_addr    <= '0;
			d_addr    <= '0;
			w_busy    <= 1'b0;
			d_busy    <= 1'b0;
			last_pipe <= '0;
			o_w_req   <= '0;
			o_d_req   <= '0;
		end else begin
			o_w_req.en <= 1'b0;  // Request strobes last one cycle
			o_d_req.en <= 1'b0;
			last_pipe  <= {last_pipe[1:0], 1'b0};
			if (start_ok) begin
				// Latch the layer config
				atoms_q  <= i_atoms;
				points_q <= i_points;
				w_addr   <= i_weight_base;
				d_addr   <= i_data_base;
				point    <= '0;
				tap      <= '0;
				w_busy   <= 1'b0;
				d_busy   <= 1'b0;
				state    <= conv_engine_pkg::load_weights;
			end else begin
				case (state)
					conv_engine_pkg::load_weights: begin
						if (!w_busy) begin
							o_w_req.en   <= 1'b1;
							o_w_req.addr <= w_addr;
							w_addr       <= w_addr + conv_engine_pkg::addr_t'(`CE_LANES);
							w_busy       <= 1'b1;
						end
						if (i_w_atom_valid) begin  // Cache writes this atom at index tap
							w_busy <= 1'b0;
							if (last_tap) begin
								tap   <= '0;
								state <= conv_engine_pkg::stream;
							end else begin
								tap <= tap + 1'b1;
							end
						end
					end
					conv_engine_pkg::stream: begin
						if (!d_busy && !d_hold) begin
							o_d_req.en   <= 1'b1;
							o_d_req.addr <= d_addr;
							d_addr       <= d_addr + conv_engine_pkg::addr_t'(`CE_LANES);
							d_busy       <= 1'b1;
						end
						if (i_d_atom_valid) begin
							d_busy       <= 1'b0;
							last_pipe[0] <= last_tap;
							if (last_tap) begin
								tap   <= '0;
								point <= point + 1'b1;
								if (last_point)
									state <= conv_engine_pkg::drain;  // All atoms read
							end else begin
								tap <= tap + 1'b1;
							end
						end
					end
					conv_engine_pkg::drain: begin
						// Pipeline empty and every result written back
						if (i_wb_empty && last_pipe == '0)
							state <= conv_engine_pkg::finish;
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

//--- rtl/atom_deserializer.sv
`timescale 1ns/10ps
`include "conv_engine_config.svh"

module atom_deserializer (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   i_we,
	input  conv_engine_pkg::word_t i_data,
	output conv_engine_pkg::atom_t o_atom,
	output logic                   o_atom_valid
);

	localparam int LANE_W = $clog2(`CE_LANES);

	logic [LANE_W-1:0] lane;  // Next lane to fill

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane         <= '0;
			o_atom_valid <= 1'b0;
		end else begin
			o_atom_valid <= 1'b0;
			if (i_we) begin
				if (lane == LANE_W'(`CE_LANES - 1)) begin
					lane         <= '0;    // Wrap for the next burst
					o_atom_valid <= 1'b1;  // Atom complete
				end else begin
					lane <= lane + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_we)
			o_atom[lane] <= i_data;
	end

endmodule

//--- rtl/weight_cache.sv
`timescale 1ns/10ps
`include "conv_engine_config.svh"

module weight_cache (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       i_wr,
	input  conv_engine_pkg::atom_cnt_t i_wr_idx,
	input  conv_engine_pkg::atom_cnt_t i_rd_idx,
	input  conv_engine_pkg::atom_t     i_atom,
	output conv_engine_pkg::atom_t     o_atom
);

	// One weight atom per tap of the layer
	conv_engine_pkg::atom_t mem [`CE_MAX_ATOMS];

	always_ff @(posedge clk) begin
		if (i_wr)
			mem[i_wr_idx[$clog2(`CE_MAX_ATOMS)-1:0]] <= i_atom;
	end

	// Registered read, tap is stable long before its data atom arrives
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			o_atom <= '0;
		else
			o_atom <= mem[i_rd_idx[$clog2(`CE_MAX_ATOMS)-1:0]];
	end

endmodule

//--- rtl/mac_array.sv
`timescale 1ns/10ps
`include "conv_engine_config.svh"

module mac_array (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   i_valid,
	input  conv_engine_pkg::atom_t i_data,
	input  conv_engine_pkg::atom_t i_weight,
	output conv_engine_pkg::acc_t  o_sum,
	output logic                   o_valid
);

	logic [2*`CE_WORD_W-1:0] prod [`CE_LANES];  // Stage 1, one product per lane
	conv_engine_pkg::acc_t   tree;              // Lane sum of stage 1
	logic                    prod_valid;

	// Stage 1
	always_ff @(posedge clk) begin
		if (i_valid) begin
			for (int i = 0; i < `CE_LANES; i++)
				prod[i] <= i_data[i] * i_weight[i];
		end
	end

	// Adder tree, widened so no lane carry is lost
	always_comb begin
		tree = '0;
		for (int i = 0; i < `CE_LANES; i++)
			tree = tree + conv_engine_pkg::acc_t'(prod[i]);
	end

	// Stage 2
	always_ff @(posedge clk) begin
		if (prod_valid)
			o_sum <= tree;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prod_valid <= 1'b0;
			o_valid    <= 1'b0;
		end else begin
			prod_valid <= i_valid;
			o_valid    <= prod_valid;  // Two cycles after i_valid
		end
	end

endmodule

//--- rtl/point_accumulator.sv
`timescale 1ns/10ps

module point_accumulator (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   i_valid,
	input  logic                   i_last,
	input  conv_engine_pkg::acc_t  i_sum,
	output conv_engine_pkg::word_t o_result,
	output logic                   o_valid
);

	conv_engine_pkg::acc_t acc;
	conv_engine_pkg::acc_t acc_next;
	logic                  first;  // Next sum opens a new point

	assign acc_next = first ? i_sum : acc + i_sum;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			first   <= 1'b1;
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid && i_last;
			if (i_valid)
				first <= i_last;
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			acc <= acc_next;
			if (i_last)
				o_result <= conv_engine_pkg::word_t'(acc_next);  // Result is mod 2^16
		end
	end

endmodule

//--- rtl/result_writeback.sv
`timescale 1ns/10ps
`include "conv_engine_config.svh"

module result_writeback (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     i_valid,
	input  conv_engine_pkg::word_t   i_result,
	input  conv_engine_pkg::addr_t   i_result_base,
	input  logic                     i_start,
	input  logic                     i_ib_re,
	output conv_engine_pkg::dma_wr_t o_wr,
	output logic                     o_full,
	output logic                     o_empty
);

	localparam int PTR_W = $clog2(`CE_RESULT_DEPTH);

	conv_engine_pkg::word_t      mem [`CE_RESULT_DEPTH];
	logic [PTR_W-1:0]            wr_ptr;
	logic [PTR_W-1:0]            rd_ptr;
	logic [PTR_W:0]              count;
	conv_engine_pkg::point_cnt_t pt_cnt;   // Points written in this layer
	conv_engine_pkg::addr_t      base_q;
	logic                        re_d;     // DMA took the head last cycle
	logic                        pop;

	assign o_full  = (count == (PTR_W+1)'(`CE_RESULT_DEPTH));
	assign o_empty = (count == '0);
	assign pop     = re_d && !o_empty;

	assign o_wr.writes_en = !o_empty && !re_d;  // Dropped for the data cycle
	assign o_wr.addr      = base_q + conv_engine_pkg::addr_t'(pt_cnt);
	assign o_wr.ib_valid  = pop;
	assign o_wr.ib_data   = mem[rd_ptr];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			pt_cnt <= '0;
			re_d   <= 1'b0;
		end else begin
			re_d <= i_ib_re;
			if (i_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PTR_W+1)'(i_valid) - (PTR_W+1)'(pop);
			if (i_start)
				pt_cnt <= '0;               // Addresses restart at the new base
			else if (pop)
				pt_cnt <= pt_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid)
			mem[wr_ptr] <= i_result;
		if (i_start)
			base_q <= i_result_base;
	end

endmodule

//--- rtl/conv_engine.sv
`timescale 1ns/10ps

module conv_engine (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         i_start,
	input  conv_engine_pkg::atom_cnt_t   i_atoms,
	input  conv_engine_pkg::point_cnt_t  i_points,
	input  conv_engine_pkg::addr_t       i_data_base,
	input  conv_engine_pkg::addr_t       i_weight_base,
	input  conv_engine_pkg::addr_t       i_result_base,
	input  logic                         i_d_ob_we,
	input  conv_engine_pkg::word_t       i_d_ob_data,
	input  logic                         i_w_ob_we,
	input  conv_engine_pkg::word_t       i_w_ob_data,
	input  logic                         i_ib_re,
	output conv_engine_pkg::dma_rd_req_t o_d_req,
	output conv_engine_pkg::dma_rd_req_t o_w_req,
	output conv_engine_pkg::dma_wr_t     o_wr,
	output logic                         o_done
);

	conv_engine_pkg::atom_t     d_atom;
	conv_engine_pkg::atom_t     w_atom;
	conv_engine_pkg::atom_t     cache_atom;  // Weight atom for the current tap
	logic                       d_atom_valid;
	logic                       w_atom_valid;
	conv_engine_pkg::atom_cnt_t tap;
	logic                       last_atom;
	conv_engine_pkg::acc_t      mac_sum;
	logic                       mac_valid;
	conv_engine_pkg::word_t     result;
	logic                       result_valid;
	logic                       wb_full;
	logic                       wb_empty;

	conv_engine_ctrl u_ctrl (
		.clk            (clk),
		.rst            (rst),
		.i_start        (i_start),
		.i_atoms        (i_atoms),
		.i_points       (i_points),
		.i_data_base    (i_data_base),
		.i_weight_base  (i_weight_base),
		.i_w_atom_valid (w_atom_valid),
		.i_d_atom_valid (d_atom_valid),
		.i_wb_full      (wb_full),
		.i_wb_empty     (wb_empty),
		.o_w_req        (o_w_req),
		.o_d_req        (o_d_req),
		.o_tap          (tap),
		.o_last_atom    (last_atom),
		.o_done         (o_done)
	);

	// Weight port
	atom_deserializer u_w_deser (
		.clk          (clk),
		.rst          (rst),
		.i_we         (i_w_ob_we),
		.i_data       (i_w_ob_data),
		.o_atom       (w_atom),
		.o_atom_valid (w_atom_valid)
	);

	// Data port
	atom_deserializer u_d_deser (
		.clk          (clk),
		.rst          (rst),
		.i_we         (i_d_ob_we),
		.i_data       (i_d_ob_data),
		.o_atom       (d_atom),
		.o_atom_valid (d_atom_valid)
	);

	// Weight atoms only arrive during weight load, so their valid is the write strobe
	weight_cache u_weight_cache (
		.clk      (clk),
		.rst      (rst),
		.i_wr     (w_atom_valid),
		.i_wr_idx (tap),
		.i_rd_idx (tap),
		.i_atom   (w_atom),
		.o_atom   (cache_atom)
	);

	mac_array u_mac_array (
		.clk      (clk),
		.rst      (rst),
		.i_valid  (d_atom_valid),
		.i_data   (d_atom),
		.i_weight (cache_atom),
		.o_sum    (mac_sum),
		.o_valid  (mac_valid)
	);

	point_accumulator u_point_acc (
		.clk      (clk),
		.rst      (rst),
		.i_valid  (mac_valid),
		.i_last   (last_atom),
		.i_sum    (mac_sum),
		.o_result (result),
		.o_valid  (result_valid)
	);

	result_writeback u_writeback (
		.clk           (clk),
		.rst           (rst),
		.i_valid       (result_valid),
		.i_result      (result),
		.i_result_base (i_result_base),
		.i_start       (i_start),
		.i_ib_re       (i_ib_re),
		.o_wr          (o_wr),
		.o_full        (wb_full),
		.o_empty       (wb_empty)
	);

endmodule

//--- verif/dma_model.sv
`timescale 1ns/10ps
`include "conv_engine_config.svh"

module dma_model (
	input  logic                         clk,
	input  conv_engine_pkg::dma_rd_req_t i_d_req,
	input  conv_engine_pkg::dma_rd_req_t i_w_req,
	input  conv_engine_pkg::dma_wr_t     i_wr,
	input  logic                         i_slow_wr,      // Stretches the ib_re delay
	output logic                         o_d_ob_we,
	output conv_engine_pkg::word_t       o_d_ob_data,
	output logic                         o_w_ob_we,
	output conv_engine_pkg::word_t       o_w_ob_data,
	output logic                         o_ib_re,
	output logic                         o_req_overlap   // Sticky, a second request came early
);

	localparam int MEM_WORDS = 4096;

	conv_engine_pkg::word_t d_mem [MEM_WORDS];   // Data atoms
	conv_engine_pkg::word_t w_mem [MEM_WORDS];   // Weight atoms
	conv_engine_pkg::word_t cap_data [256];      // Every ib_valid word in arrival order
	conv_engine_pkg::addr_t cap_addr [256];
	int                     cap_count = 0;
	integer                 seed = 32'h5e2e;
	int                     d_reqs = 0;          // Requests seen per port
	int                     w_reqs = 0;
	int                     d_bursts = 0;        // Bursts finished per port
	int                     w_bursts = 0;
	logic                   overlap = 1'b0;

	assign o_req_overlap = overlap;

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	initial begin
		for (int a = 0; a < MEM_WORDS; a++) begin
			d_mem[12'(a)] = conv_engine_pkg::word_t'($random(seed));
			w_mem[12'(a)] = conv_engine_pkg::word_t'($random(seed));
		end
	end

	// Data read port, 16 words per request
	initial begin
		conv_engine_pkg::addr_t addr;
		o_d_ob_we   = 1'b0;
		o_d_ob_data = '0;
		forever begin
			@(negedge clk);
			if (i_d_req.en) begin
				addr = i_d_req.addr;
				repeat (rand_below(6)) @(posedge clk);  // Request latency
				for (int i = 0; i < `CE_LANES; i++) begin
					repeat (rand_below(3)) begin  // Gap before this word
						@(posedge clk);
						#1;
						o_d_ob_we = 1'b0;
					end
					@(posedge clk);
					#1;
					o_d_ob_we   = 1'b1;
					o_d_ob_data = d_mem[12'(addr + conv_engine_pkg::addr_t'(i))];
				end
				@(posedge clk);
				#1;
				o_d_ob_we = 1'b0;
				d_bursts  = d_bursts + 1;
			end
		end
	end

	// Weight read port, same timing as the data port
	initial begin
		conv_engine_pkg::addr_t addr;
		o_w_ob_we   = 1'b0;
		o_w_ob_data = '0;
		forever begin
			@(negedge clk);
			if (i_w_req.en) begin
				addr = i_w_req.addr;
				repeat (rand_below(6)) @(posedge clk);
				for (int i = 0; i < `CE_LANES; i++) begin
					repeat (rand_below(3)) begin
						@(posedge clk);
						#1;
						o_w_ob_we = 1'b0;
					end
					@(posedge clk);
					#1;
					o_w_ob_we   = 1'b1;
					o_w_ob_data = w_mem[12'(addr + conv_engine_pkg::addr_t'(i))];
				end
				@(posedge clk);
				#1;
				o_w_ob_we = 1'b0;
				w_bursts  = w_bursts + 1;
			end
		end
	end

	// Write port, one ib_re pulse per waiting result
	initial begin
		int wait_cycles;
		o_ib_re = 1'b0;
		forever begin
			@(negedge clk);
			if (i_wr.writes_en) begin
				wait_cycles = i_slow_wr ? 60 + rand_below(31) : rand_below(4);
				repeat (wait_cycles) @(posedge clk);
				@(posedge clk);
				#1;
				o_ib_re = 1'b1;
				@(posedge clk);
				#1;
				o_ib_re = 1'b0;
			end
		end
	end

	// Capture of written words and request bookkeeping
	always @(negedge clk) begin
		if (i_wr.ib_valid) begin
			cap_data[8'(cap_count)] = i_wr.ib_data;
			cap_addr[8'(cap_count)] = i_wr.addr;
			cap_count = cap_count + 1;
		end
		if (i_d_req.en) begin
			if (d_reqs != d_bursts)
				overlap = 1'b1;  // Previous data burst still running
			d_reqs = d_reqs + 1;
		end
		if (i_w_req.en) begin
			if (w_reqs != w_bursts)
				overlap = 1'b1;
			w_reqs = w_reqs + 1;
		end
	end

endmodule

//--- verif/conv_engine_tb.sv
`timescale 1ns/10ps
`include "conv_engine_config.svh"

module conv_engine_tb;

	localparam int RESET_CYCLES = 16;
	// Worst read burst: latency 5, 16 words with up to 2 idle cycles each, request overhead
	localparam int ATOM_CYCLES    = 5 + 3 * `CE_LANES + 4;
	// Weight atoms plus data atoms of the five layers
	localparam int TOTAL_ATOMS    = (4 + 4 * 8) + (16 + 16 * 2) + (1 + 6) + (1 + 10) + (3 + 3 * 5);
	localparam int SLOW_WR_CYCLES = 60 + 30 + 3;  // Longest ib_re delay plus the write cycles
	localparam int SLOW_POINTS    = 10;
	localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + TOTAL_ATOMS * ATOM_CYCLES +
		SLOW_POINTS * SLOW_WR_CYCLES);

	logic                         clk;
	logic                         rst;
	logic                         start;
	conv_engine_pkg::atom_cnt_t   atoms;
	conv_engine_pkg::point_cnt_t  points;
	conv_engine_pkg::addr_t       data_base;
	conv_engine_pkg::addr_t       weight_base;
	conv_engine_pkg::addr_t       result_base;
	logic                         slow_wr;
	logic                         d_ob_we;
	logic                         w_ob_we;
	logic                         ib_re;
	conv_engine_pkg::word_t       d_ob_data;
	conv_engine_pkg::word_t       w_ob_data;
	conv_engine_pkg::dma_rd_req_t d_req;
	conv_engine_pkg::dma_rd_req_t w_req;
	conv_engine_pkg::dma_wr_t     wr;
	logic                         done;
	logic                         req_overlap;
	int                           cycles = 0;

	conv_engine conv_engine_inst (
		.clk           (clk),
		.rst           (rst),
		.i_start       (start),
		.i_atoms       (atoms),
		.i_points      (points),
		.i_data_base   (data_base),
		.i_weight_base (weight_base),
		.i_result_base (result_base),
		.i_d_ob_we     (d_ob_we),
		.i_d_ob_data   (d_ob_data),
		.i_w_ob_we     (w_ob_we),
		.i_w_ob_data   (w_ob_data),
		.i_ib_re       (ib_re),
		.o_d_req       (d_req),
		.o_w_req       (w_req),
		.o_wr          (wr),
		.o_done        (done)
	);

	dma_model dma (
		.clk           (clk),
		.i_d_req       (d_req),
		.i_w_req       (w_req),
		.i_wr          (wr),
		.i_slow_wr     (slow_wr),
		.o_d_ob_we     (d_ob_we),
		.o_d_ob_data   (d_ob_data),
		.o_w_ob_we     (w_ob_we),
		.o_w_ob_data   (w_ob_data),
		.o_ib_re       (ib_re),
		.o_req_overlap (req_overlap)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;  // 8 ns period

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string test, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (expected == actual)
		else fail_now($sformatf("FAILED %s %s: expected %0h, actual %0h",
			test, what, expected, actual));
	endtask

	// Sum of data times weight over all lanes and atoms of one point, mod 2^16
	function automatic conv_engine_pkg::word_t ref_point(input int n_atoms, input int p,
		input conv_engine_pkg::addr_t d_base, input conv_engine_pkg::addr_t w_base);
		conv_engine_pkg::word_t sum;
		int d_idx;
		int w_idx;
		sum = '0;
		for (int a = 0; a < n_atoms; a++) begin
			for (int l = 0; l < `CE_LANES; l++) begin
				d_idx = int'(d_base) + (p * n_atoms + a) * `CE_LANES + l;  // Atoms back to back
				w_idx = int'(w_base) + a * `CE_LANES + l;
				sum = sum + conv_engine_pkg::word_t'(dma.d_mem[12'(d_idx)] *
					dma.w_mem[12'(w_idx)]);
			end
		end
		return sum;
	endfunction

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES)
			fail_now("Timeout: the engine did not finish all layers in time");
	end

	assert property (@(posedge clk) rst |->
		!(d_req.en || w_req.en || wr.writes_en || wr.ib_valid || done))
	else fail_now("An output was active while reset was asserted");

	assert property (@(posedge clk) !req_overlap)
	else fail_now("A read request was issued while the previous one was still outstanding");

	// Write data only in the cycle after the DMA took it
	assert property (@(posedge clk) disable iff (rst) wr.ib_valid |-> $past(ib_re))
	else fail_now("ib_valid pulsed without an ib_re in the cycle before");

	// Every ib_re gets its word next cycle, writes_en low in that cycle
	assert property (@(posedge clk) disable iff (rst) ib_re |=> (wr.ib_valid && !wr.writes_en))
	else fail_now("ib_re was not answered by ib_valid with writes_en low in the next cycle");

	// Queue is empty once the layer is done
	assert property (@(posedge clk) disable iff (rst) done |-> !wr.writes_en)
	else fail_now("writes_en was high while the engine reported done");

	task automatic run_layer(input string test, input int n_atoms, input int n_points,
		input conv_engine_pkg::addr_t d_base, input conv_engine_pkg::addr_t w_base,
		input conv_engine_pkg::addr_t r_base, input logic slow);
		int first;
		first = dma.cap_count;
		@(posedge clk);
		#1;
		atoms       = conv_engine_pkg::atom_cnt_t'(n_atoms);
		points      = conv_engine_pkg::point_cnt_t'(n_points);
		data_base   = d_base;
		weight_base = w_base;
		result_base = r_base;
		slow_wr     = slow;
		start       = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		@(negedge clk);
		check_value(test, "done right after start", 32'd0, 32'(done));
		while (!done)
			@(negedge clk);  // Bounded by the cycle counter
		check_value(test, "write count at done", 32'(n_points), 32'(dma.cap_count - first));
		for (int p = 0; p < n_points; p++) begin
			check_value(test, $sformatf("address of point %0d", p),
				32'(r_base) + 32'(p), 32'(dma.cap_addr[8'(first + p)]));
			check_value(test, $sformatf("result of point %0d", p),
				32'(ref_point(n_atoms, p, d_base, w_base)), 32'(dma.cap_data[8'(first + p)]));
		end
		repeat (8) @(negedge clk);
		check_value(test, "write count after done", 32'(n_points),
			32'(dma.cap_count - first));
	endtask

	initial begin
		rst         = 1'b1;
		start       = 1'b0;
		atoms       = '0;
		points      = '0;
		data_base   = '0;
		weight_base = '0;
		result_base = '0;
		slow_wr     = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (4) begin  // Engine stays quiet in idle
			@(negedge clk);
			assert (!(d_req.en || w_req.en || wr.writes_en || wr.ib_valid || done))
			else fail_now("An output was active right after reset");
		end

		run_layer("basic_atoms4", 4, 8, 30'h000, 30'h000, 30'h0100_0000, 1'b0);

		// All ones data forces the 16 bit wrap
		for (int i = 0; i < 2 * 16 * `CE_LANES; i++)
			dma.d_mem[12'(32'h200 + i)] = 16'hFFFF;
		run_layer("edge_atoms16_wrap", 16, 2, 30'h200, 30'h100, 30'h0200_0000, 1'b0);
		run_layer("edge_atoms1", 1, 6, 30'h400, 30'h200, 30'h0300_0010, 1'b0);
		run_layer("slow_write", 1, SLOW_POINTS, 30'h480, 30'h210, 30'h0400_0000, 1'b1);
		run_layer("second_layer", 3, 5, 30'h600, 30'h300, 30'h0500_0100, 1'b0);

		$display("Testbench passed");
		$finish;
	end

endmodule

//--- conv_engine.f
+incdir+include
rtl/conv_engine_pkg.sv
rtl/conv_engine_ctrl.sv
rtl/atom_deserializer.sv
rtl/weight_cache.sv
rtl/mac_array.sv
rtl/point_accumulator.sv
rtl/result_writeback.sv
rtl/conv_engine.sv
verif/dma_model.sv
verif/conv_engine_tb.sv

//--- run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module conv_engine_tb \
	-f conv_engine.f -o conv_engine_sim

./obj_dir/conv_engine_sim | tee sim.log

if grep -q "Testbench passed" sim.log; then
	echo "Simulation result: pass"
	exit 0
fi
echo "Simulation result: fail"
exit 1
